/* logic/prom_geom_pkg.sv */
// array geometry and address field types, imported by every PROM block
`default_nettype none

package prom_geom_pkg;

    // ----------------------------------------
    // array geometry
    // ----------------------------------------
    localparam int NUM_BANKS  = 16;
    localparam int NUM_BLOCKS = 128;
    localparam int NUM_WORDS  = 16;   // words per block

    // ----------------------------------------
    // field widths
    // ----------------------------------------
    localparam int ADDR_W  = 23;
    localparam int WORD_W  = 16;
    localparam int BANK_W  = $clog2(NUM_BANKS);
    localparam int BLOCK_W = $clog2(NUM_BLOCKS);
    localparam int WIDX_W  = $clog2(NUM_WORDS);

    // one data word of the array or the bus
    typedef logic [WORD_W-1:0]  word_t;

    // full bus address
    typedef logic [ADDR_W-1:0]  addr_t;

    // addr[22:19], eight blocks per bank
    typedef logic [BANK_W-1:0]  bank_t;

    // addr[22:16], the bank bits sit on top
    typedef logic [BLOCK_W-1:0] block_t;

    // addr[3:0]
    typedef logic [WIDX_W-1:0]  word_idx_t;

endpackage

`default_nettype wire

/* logic/prom_cmd_pkg.sv */
// command codes, signature constants and bus/mode structs of the PROM model
`default_nettype none

package prom_cmd_pkg;

    // ----------------------------------------
    // command codes written on the data bus
    // ----------------------------------------
    typedef enum logic [15:0] {
        CMD_READ_ARRAY     = 16'h00FF,
        CMD_READ_STATUS    = 16'h0070,
        CMD_READ_SIG       = 16'h0090,
        CMD_PROGRAM        = 16'h0040,
        CMD_LOCK_SETUP     = 16'h0060,
        CMD_UNLOCK_CONFIRM = 16'h00D0,   // only meaningful after lock setup
        CMD_LOCK_CONFIRM   = 16'h0001    // same
    } cmd_e;

    // ----------------------------------------
    // electronic signature and status
    // ----------------------------------------
    localparam prom_geom_pkg::word_t MFR_CODE    = 16'h0049;
    localparam prom_geom_pkg::word_t DEVICE_CODE = 16'h506B;
    localparam logic [11:0]          CONFIG_TAG  = 12'hCCC;  // bank goes below it
    localparam logic [3:0]           STATUS_TAG  = 4'hF;
    localparam logic [7:0]           STATUS_READY = 8'h80;   // ready, no errors

    // word offsets inside the signature space of a bank
    localparam prom_geom_pkg::word_idx_t SIG_OFS_MFR  = 4'd0;
    localparam prom_geom_pkg::word_idx_t SIG_OFS_DEV  = 4'd1;
    localparam prom_geom_pkg::word_idx_t SIG_OFS_LOCK = 4'd2;
    localparam prom_geom_pkg::word_idx_t SIG_OFS_CFG  = 4'd5;

    // host bus, one strobe per cycle
    typedef struct packed {
        logic                 cs;
        logic                 wr;
        logic                 rd;
        prom_geom_pkg::addr_t addr;
        prom_geom_pkg::word_t wdata;
    } prom_bus_t;

    // what the read path needs from the controller
    typedef struct packed {
        cmd_e mode;     // command of addressed bank
        logic locked;   // lock bit of addressed block
    } rd_ctx_t;

endpackage

`default_nettype wire

/* logic/prom_ctrl.sv */
// per-bank command FSM and block lock table, decides program writes for prom_top
`timescale 1ns/1ns
`default_nettype none

module prom_ctrl
(
    input  wire logic                   we_b,
    input  wire logic                   rst,
    input  wire logic                   wr,
    input  wire prom_geom_pkg::bank_t   bank,
    input  wire prom_geom_pkg::block_t  block,
    input  wire prom_geom_pkg::word_t   wdata,
    output logic                        prog_we,
    output prom_cmd_pkg::rd_ctx_t       rd_ctx
);

    import prom_geom_pkg::*;
    import prom_cmd_pkg::*;

    // ----------------------------------------
    // state
    // ----------------------------------------
    cmd_e                  cmd_q [NUM_BANKS];  // one command register per bank
    logic [NUM_BLOCKS-1:0] lock_q;              // 1 = locked
    logic [NUM_BANKS-1:0]  done_q;              // program session used up

    cmd_e cur_cmd;
    logic is_reset_cmd;
    logic new_cmd_ok;
    logic prog_slot;

    assign cur_cmd      = cmd_q[bank];
    assign is_reset_cmd = (wdata == CMD_READ_ARRAY);

    // codes that may start a new mode from a read mode
    // confirm codes are left out, they have no meaning here
    assign new_cmd_ok = wdata inside {CMD_READ_ARRAY, CMD_READ_STATUS, CMD_READ_SIG,
                                      CMD_PROGRAM, CMD_LOCK_SETUP};

    // first non-reset write of an open program session
    assign prog_slot = wr && (cur_cmd == CMD_PROGRAM) && !done_q[bank] && !is_reset_cmd;

    // ----------------------------------------
    // program strobe, same cycle as the bus write
    // ----------------------------------------
    always_comb
    begin
        prog_we = 1'b0;
        if (prog_slot)
            prog_we = !lock_q[block];   // locked block swallows the data
    end

    // ----------------------------------------
    // command, lock and session update
    // ----------------------------------------
    always_ff @(posedge we_b)
    begin
        if (rst)
        begin
            for (int i = 0; i < NUM_BANKS; i++)
                cmd_q[i] <= CMD_READ_ARRAY;
            lock_q <= '1;   // everything locked out of reset
            done_q <= '0;
        end
        else if (wr)
        begin
            if (is_reset_cmd)
            begin
                // 00FF wins in every mode
                cmd_q[bank]  <= CMD_READ_ARRAY;
                done_q[bank] <= 1'b0;
            end
            else
            begin
                case (cur_cmd)
                    CMD_READ_ARRAY, CMD_READ_STATUS, CMD_READ_SIG:
                    begin
                        if (new_cmd_ok)
                        begin
                            cmd_q[bank]  <= cmd_e'(wdata);
                            done_q[bank] <= 1'b0;   // fresh session on entry
                        end
                    end

                    CMD_LOCK_SETUP:
                    begin
                        if (wdata == CMD_UNLOCK_CONFIRM)
                            lock_q[block] <= 1'b0;
                        else if (wdata == CMD_LOCK_CONFIRM)
                            lock_q[block] <= 1'b1;
                        cmd_q[bank] <= CMD_READ_ARRAY;  // any data ends the setup
                    end

                    CMD_PROGRAM:
                    begin
                        // one shot per session, locked or not
                        if (!done_q[bank])
                            done_q[bank] <= 1'b1;
                    end
                endcase
            end
        end
    end

    // ----------------------------------------
    // context for the read path
    // ----------------------------------------
    always_comb
    begin
        rd_ctx.mode   = cur_cmd;
        rd_ctx.locked = lock_q[block];
    end

endmodule

`default_nettype wire

/* logic/prom_array.sv */
// block/word storage of the PROM, loaded with its address pattern in reset
`timescale 1ns/1ns
`default_nettype none

module prom_array
(
    input  wire logic                      we_b,
    input  wire logic                      rst,
    input  wire logic                      prog_we,
    input  wire prom_geom_pkg::block_t     block,
    input  wire prom_geom_pkg::word_idx_t  word,
    input  wire prom_geom_pkg::word_t      wdata,
    output prom_geom_pkg::word_t           array_word
);

    import prom_geom_pkg::*;

    // ----------------------------------------
    // storage
    // ----------------------------------------
    word_t mem [NUM_BLOCKS][NUM_WORDS];

    // reset content, block number high byte, word number low byte
    function automatic word_t init_word(input int blk, input int wd);
        logic [7:0] hi;
        logic [7:0] lo;
        hi = 8'(blk);
        lo = 8'(wd);
        return {hi, lo};
    endfunction

    // ----------------------------------------
    // write port
    // ----------------------------------------
    always_ff @(posedge we_b)
    begin
        if (rst)
        begin
            // whole array gets its pattern back
            for (int b = 0; b < NUM_BLOCKS; b++)
            begin
                for (int w = 0; w < NUM_WORDS; w++)
                begin
                    mem[b][w] <= init_word(b, w);
                end
            end
        end
        else if (prog_we)
        begin
            mem[block][word] <= wdata;   // lock check already done upstream
        end
    end

    // ----------------------------------------
    // read port
    // ----------------------------------------
    // no latency, the read mux registers it
    assign array_word = mem[block][word];

endmodule

`default_nettype wire

/* logic/prom_read_mux.sv */
// registered read path of the PROM, picks array, status or signature word
`timescale 1ns/1ns
`default_nettype none

module prom_read_mux
(
    input  wire logic                      we_b,
    input  wire logic                      rst,
    input  wire logic                      rd,
    input  wire prom_geom_pkg::bank_t      bank,
    input  wire prom_geom_pkg::word_idx_t  word,
    input  wire prom_cmd_pkg::rd_ctx_t     rd_ctx,
    input  wire prom_geom_pkg::word_t      array_word,
    output prom_geom_pkg::word_t           rd_data,
    output logic                           rd_valid
);

    import prom_geom_pkg::*;
    import prom_cmd_pkg::*;

    word_t status_word;
    word_t config_word;
    word_t lock_word;
    word_t sel_word;

    // bank dependent words
    assign status_word = {STATUS_TAG, bank, STATUS_READY};
    assign config_word = {CONFIG_TAG, bank};
    assign lock_word   = word_t'(rd_ctx.locked);   // bit 0 only

    // ----------------------------------------
    // word select by mode
    // ----------------------------------------
    always_comb
    begin
        case (rd_ctx.mode)
            CMD_READ_ARRAY:
                sel_word = array_word;
            CMD_READ_SIG:
            begin
                case (word)
                    SIG_OFS_MFR:  sel_word = MFR_CODE;
                    SIG_OFS_DEV:  sel_word = DEVICE_CODE;
                    SIG_OFS_LOCK: sel_word = lock_word;
                    SIG_OFS_CFG:  sel_word = config_word;
                    default:      sel_word = '0;
                endcase
            end
            default:
                sel_word = status_word;   // status, program and setup modes
        endcase
    end

    // ----------------------------------------
    // output register
    // ----------------------------------------
    always_ff @(posedge we_b)
    begin
        if (rst)
            rd_valid <= 1'b0;
        else
            rd_valid <= rd;   // exactly one cycle per strobe
    end

    always_ff @(posedge we_b)
    begin
        if (rd)
            rd_data <= sel_word;
    end

endmodule

`default_nettype wire

/* logic/prom_top.sv */
// top of the banked PROM model, the testbench drives its bus and reads back
`timescale 1ns/1ns
`default_nettype none

module prom_top
(
    input  wire logic                    we_b,
    input  wire logic                    rst,
    input  wire prom_cmd_pkg::prom_bus_t bus,
    output prom_geom_pkg::word_t         rd_data,
    output logic                         rd_valid
);

    import prom_geom_pkg::*;
    import prom_cmd_pkg::*;

    logic      wr_s;
    logic      rd_s;
    bank_t     bank;
    block_t    block;
    word_idx_t word;
    logic      prog_we;
    rd_ctx_t   rd_ctx;
    word_t     array_word;

    // ----------------------------------------
    // strobes and address fields
    // ----------------------------------------
    assign wr_s  = bus.cs & bus.wr;
    assign rd_s  = bus.cs & bus.rd;
    assign bank  = bus.addr[ADDR_W-1 -: BANK_W];
    assign block = bus.addr[ADDR_W-1 -: BLOCK_W];   // overlaps the bank bits
    assign word  = bus.addr[WIDX_W-1:0];

    prom_ctrl u_ctrl
    (
        .we_b    (we_b),
        .rst     (rst),
        .wr      (wr_s),
        .bank    (bank),
        .block   (block),
        .wdata   (bus.wdata),
        .prog_we (prog_we),
        .rd_ctx  (rd_ctx)
    );

    prom_array u_array
    (
        .we_b       (we_b),
        .rst        (rst),
        .prog_we    (prog_we),
        .block      (block),
        .word       (word),
        .wdata      (bus.wdata),
        .array_word (array_word)
    );

    prom_read_mux u_read_mux
    (
        .we_b       (we_b),
        .rst        (rst),
        .rd         (rd_s),
        .bank       (bank),
        .word       (word),
        .rd_ctx     (rd_ctx),
        .array_word (array_word),
        .rd_data    (rd_data),
        .rd_valid   (rd_valid)
    );

endmodule

`default_nettype wire

/* tb/prom_props.sv */
// bound checks on read strobe timing, reset state and program guarding of prom_top
`timescale 1ns/1ns
`default_nettype none

module prom_props
(
    input wire logic                  we_b,
    input wire logic                  rst,
    input wire logic                  rd_s,
    input wire logic                  rd_valid,
    input wire logic                  wr_s,
    input wire prom_cmd_pkg::cmd_e    mode,
    input wire prom_geom_pkg::block_t block,
    input wire prom_geom_pkg::word_t  wdata,
    input wire logic                  prog_we
);

    import prom_geom_pkg::*;
    import prom_cmd_pkg::*;

    int fail_cnt = 0;

    // lock bits rebuilt from the confirm writes seen on the bus
    logic [NUM_BLOCKS-1:0] lock_seen;

    always_ff @(posedge we_b)
    begin
        if (rst)
            lock_seen <= '1;
        else if (wr_s && mode == CMD_LOCK_SETUP)
        begin
            if (wdata == CMD_UNLOCK_CONFIRM)
                lock_seen[block] <= 1'b0;
            else if (wdata == CMD_LOCK_CONFIRM)
                lock_seen[block] <= 1'b1;
        end
    end

    // rd_valid follows a read strobe by exactly one cycle
    a_rd_valid_on: assert property (@(posedge we_b) disable iff (rst) rd_s |=> rd_valid)
    else
    begin
        $error("rd_valid missing one cycle after a read strobe");
        fail_cnt++;
    end

    a_rd_valid_off: assert property (@(posedge we_b) disable iff (rst) !rd_s |=> !rd_valid)
    else
    begin
        $error("rd_valid high without a read strobe");
        fail_cnt++;
    end

    // first cycle out of reset
    a_reset_idle: assert property (@(posedge we_b) $fell(rst) |-> !rd_valid)
    else
    begin
        $error("rd_valid high right after reset");
        fail_cnt++;
    end

    a_prog_guard: assert property (@(posedge we_b) disable iff (rst)
                                   prog_we |-> !lock_seen[block])
    else
    begin
        $error("program strobe while the addressed block is locked");
        fail_cnt++;
    end

endmodule

`default_nettype wire

/* tb/prom_tb.sv */
// self-checking testbench for prom_top, command, lock, program and read tests
`timescale 1ns/1ns
`default_nettype none

module prom_tb;

    import prom_geom_pkg::*;
    import prom_cmd_pkg::*;

    localparam int TEST_CYCLES = 260;   // rough sum over all tests

    logic      we_b;
    logic      rst;
    prom_bus_t bus;
    word_t     rd_data;
    logic      rd_valid;

    integer seed   = 32'h84e83332;
    int     errors = 0;
    int     checks = 0;
    word_t  exp_q [$];   // one entry per read strobe

    // shadow of the device state
    logic [15:0] sh_cmd  [NUM_BANKS];
    logic        sh_lock [NUM_BLOCKS];
    logic        sh_done [NUM_BANKS];
    word_t       sh_mem  [NUM_BLOCKS][NUM_WORDS];

    prom_top uut
    (
        .we_b     (we_b),
        .rst      (rst),
        .bus      (bus),
        .rd_data  (rd_data),
        .rd_valid (rd_valid)
    );

    bind prom_top prom_props u_props
    (
        .we_b     (we_b),
        .rst      (rst),
        .rd_s     (rd_s),
        .rd_valid (rd_valid),
        .wr_s     (wr_s),
        .mode     (rd_ctx.mode),
        .block    (block),
        .wdata    (bus.wdata),
        .prog_we  (prog_we)
    );

    always #2 we_b = ~we_b;

    function automatic addr_t make_addr(input int blk, input int wd);
        return {7'(blk), 12'h000, 4'(wd)};
    endfunction

    // ----------------------------------------
    // reference model
    // ----------------------------------------
    function automatic void apply_write(input addr_t a, input word_t d);
        int bk;
        int bl;
        bk = a[22:19];
        bl = a[22:16];
        if (d == 16'h00FF)
        begin
            sh_cmd[bk]  = 16'h00FF;
            sh_done[bk] = 1'b0;
        end
        else if (sh_cmd[bk] == 16'h0060)
        begin
            if (d == 16'h00D0)
                sh_lock[bl] = 1'b0;
            else if (d == 16'h0001)
                sh_lock[bl] = 1'b1;
            sh_cmd[bk] = 16'h00FF;   // setup always ends here
        end
        else if (sh_cmd[bk] == 16'h0040)
        begin
            if (!sh_done[bk] && !sh_lock[bl])
                sh_mem[bl][a[3:0]] = d;
            sh_done[bk] = 1'b1;
        end
        else if (d inside {16'h0070, 16'h0090, 16'h0040, 16'h0060})
        begin
            sh_cmd[bk]  = d;
            sh_done[bk] = 1'b0;
        end
    endfunction

    function automatic word_t expect_read(input addr_t a);
        logic [3:0] bk;
        logic [6:0] bl;
        bk = a[22:19];
        bl = a[22:16];
        case (sh_cmd[bk])
            16'h00FF: return sh_mem[bl][a[3:0]];
            16'h0090:
                case (a[3:0])
                    4'd0:    return 16'h0049;
                    4'd1:    return 16'h506B;
                    4'd2:    return {15'b0, sh_lock[bl]};
                    4'd5:    return {12'hCCC, bk};
                    default: return 16'h0000;
                endcase
            default: return {4'hF, bk, 8'h80};   // status word
        endcase
    endfunction

    // ----------------------------------------
    // bus tasks, one cycle each
    // ----------------------------------------
    task automatic bus_write(input addr_t a, input word_t d);
        apply_write(a, d);
        bus = '{cs: 1'b1, wr: 1'b1, rd: 1'b0, addr: a, wdata: d};
        @(posedge we_b);
        #1;
        bus = '0;
    endtask

    task automatic bus_read(input addr_t a);
        exp_q.push_back(expect_read(a));
        bus = '{cs: 1'b1, wr: 1'b0, rd: 1'b1, addr: a, wdata: 16'h0000};
        @(posedge we_b);
        #1;
        bus = '0;
    endtask

    task automatic finish_test(input string name, input int err0);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 10)
        begin
            @(posedge we_b);
            n++;
        end
        #1;
        if (exp_q.size() != 0)
        begin
            $display("%0d reads never returned rd_valid", exp_q.size());
            errors += exp_q.size();
            exp_q.delete();
        end
        $display("test %s done, %0d errors", name, errors - err0);
    endtask

    // compare at the falling edge, rd_data is stable there
    always @(negedge we_b)
    begin
        word_t want;
        if (rd_valid)
        begin
            if (exp_q.size() == 0)
            begin
                $display("rd_valid high at %0t with no read pending", $time);
                errors++;
            end
            else
            begin
                want = exp_q.pop_front();
                checks++;
                assert (rd_data === want)
                else
                begin
                    $display("FAILED %0t: rd_data %h, expected %h", $time, rd_data, want);
                    errors++;
                end
            end
        end
    end

    initial
    begin
        #(TEST_CYCLES * 4 + 400);
        $display("timeout, tests still running after %0d ns", TEST_CYCLES * 4 + 400);
        $display("SOME TESTS FAILED");
        $finish;
    end

    // ----------------------------------------
    // stimulus
    // ----------------------------------------
    initial
    begin
        int    e0;
        int    blk;
        addr_t a;
        we_b = 1'b0;
        rst  = 1'b1;
        bus  = '0;
        for (int b = 0; b < NUM_BLOCKS; b++)
        begin
            sh_lock[b] = 1'b1;
            for (int w = 0; w < NUM_WORDS; w++)
                sh_mem[b][w] = {8'(b), 8'(w)};
        end
        for (int k = 0; k < NUM_BANKS; k++)
        begin
            sh_cmd[k]  = 16'h00FF;
            sh_done[k] = 1'b0;
        end
        repeat (3) @(posedge we_b);
        #1;
        rst = 1'b0;

        e0 = errors;
        repeat (40)
            bus_read(addr_t'($random(seed)));
        finish_test("reset pattern", e0);

        // locked first, then unlocked
        e0  = errors;
        blk = $random(seed) & 127;
        a   = make_addr(blk, 3);
        bus_write(a, 16'h0040);
        bus_write(a, 16'hA5A5);
        bus_write(a, 16'h00FF);
        bus_read(a);
        bus_write(a, 16'h0060);
        bus_write(a, 16'h00D0);
        bus_write(a, 16'h0040);
        bus_write(a, 16'h5A5A);
        bus_write(a, 16'h00FF);
        bus_read(a);
        finish_test("lock and program", e0);

        e0  = errors;
        blk = (blk + 37) & 127;
        a   = make_addr(blk, 7);
        bus_write(a, 16'h0060);
        bus_write(a, 16'h00D0);
        bus_write(a, 16'h0040);
        bus_write(a, word_t'($random(seed)));
        bus_write(make_addr(blk, 8), 16'h1234);   // same session, dropped
        bus_write(a, 16'h00FF);
        bus_read(a);
        bus_read(make_addr(blk, 8));
        bus_write(a, 16'h0040);
        bus_write(make_addr(blk, 8), 16'hBEEF);
        bus_write(a, 16'h00FF);
        bus_read(make_addr(blk, 8));
        finish_test("one program per session", e0);

        e0 = errors;
        for (int bk = 0; bk < NUM_BANKS; bk++)
        begin
            a = make_addr(bk * 8 + ($random(seed) & 7), 0);
            bus_write(a, 16'h0090);
            for (int wd = 0; wd < 6; wd++)
                bus_read(a + addr_t'(wd));
            bus_write(a, 16'h0070);
            bus_read(a);
            bus_write(a, 16'h00FF);
        end
        finish_test("signature and status", e0);

        e0 = errors;
        bus_write(make_addr(16, 0), 16'h0070);   // bank 2
        bus_write(make_addr(72, 0), 16'h0090);   // bank 9
        bus_read(make_addr(17, 4));
        bus_read(make_addr(75, 1));
        bus_read(make_addr(40, 2));              // bank 5 untouched
        bus_write(make_addr(16, 0), 16'h00FF);
        bus_write(make_addr(72, 0), 16'h00FF);
        a = make_addr(26, 9);
        bus_write(a, 16'h0060);
        bus_write(a, 16'h00D0);
        bus_write(a, 16'h0090);
        bus_read(make_addr(26, 2));              // unlocked reads as 0
        bus_write(a, 16'h00FF);
        bus_write(a, 16'h0060);
        bus_write(a, 16'h0001);                  // locked again
        bus_write(a, 16'h0040);
        bus_write(a, 16'hCAFE);
        bus_write(a, 16'h00FF);
        bus_read(a);
        bus_write(a, 16'h0090);
        bus_read(make_addr(26, 2));
        bus_write(a, 16'h00FF);
        finish_test("bank separation and relock", e0);

        errors += uut.u_props.fail_cnt;
        $display("5 tests, %0d reads checked, %0d errors", checks, errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
logic/prom_geom_pkg.sv
logic/prom_cmd_pkg.sv
logic/prom_ctrl.sv
logic/prom_array.sv
logic/prom_read_mux.sv
logic/prom_top.sv
tb/prom_props.sv
tb/prom_tb.sv

/* Bender.yml */
package:
  name: prom_model

sources:
  - files:
      - logic/prom_geom_pkg.sv
      - logic/prom_cmd_pkg.sv
      - logic/prom_ctrl.sv
      - logic/prom_array.sv
      - logic/prom_read_mux.sv
      - logic/prom_top.sv
  - target: test
    files:
      - tb/prom_props.sv
      - tb/prom_tb.sv
